// ==== common/cache_pkg.sv ====
// l1 data cache shared definitions

package cache_pkg;

    // fixed geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS      = 8;

    // address field widths
    localparam int BLOCK_BITS  = $clog2(BLOCK_WORDS);
    localparam int SET_BITS    = $clog2(N_SETS);
    // two byte offset bits inside a word
    localparam int TAG_BITS    = WORD_W - SET_BITS - BLOCK_BITS - 2;

    // data or address word
    typedef logic [WORD_W-1:0] word_t;

    // line tag
    typedef logic [TAG_BITS-1:0] tag_t;

    // set index
    typedef logic [SET_BITS-1:0] set_idx_t;

    // address split into cache fields, msb first
    typedef struct packed {
        tag_t                  tag;
        set_idx_t              set;
        logic [BLOCK_BITS-1:0] block;
        // byte within the word
        logic [1:0]            byte_off;
    } cache_addr_t;

    // same 32 bits seen as a flat word or as fields
    typedef union packed {
        word_t       word;
        cache_addr_t fields;
    } cache_addr_u;

endpackage

// ==== l1_cache/cache_way.sv ====
// one way of the l1 data cache
`timescale 1ns/1ps

module cache_way (
    input  logic                             CLK,
    input  logic                             nRST,
    input  cache_pkg::set_idx_t              set_sel,
    input  logic [cache_pkg::BLOCK_BITS-1:0] word_idx,
    input  cache_pkg::tag_t                  tag_in,
    input  cache_pkg::word_t                 wdata,
    input  logic [3:0]                       byte_en,
    input  logic                             write,
    input  logic                             fill,
    input  logic                             inval,
    output logic                             hit,
    output logic                             dirty,
    output cache_pkg::tag_t                  tag_out,
    output cache_pkg::word_t                 word_out
);
    import cache_pkg::*;

    // line state
    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_q;

    // tag and data arrays
    tag_t  tag_mem  [N_SETS];
    word_t data_mem [N_SETS][BLOCK_WORDS];

    logic last_word;

    assign last_word = (word_idx == BLOCK_BITS'(BLOCK_WORDS - 1));

    // combinational read of the selected set
    assign tag_out  = tag_mem[set_sel];
    assign word_out = data_mem[set_sel][word_idx];
    assign hit      = valid_q[set_sel] && (tag_mem[set_sel] == tag_in);
    assign dirty    = dirty_q[set_sel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (inval) begin
            valid_q[set_sel] <= 1'b0;
            dirty_q[set_sel] <= 1'b0;
        end else if (fill && last_word) begin
            // whole block now present and clean
            valid_q[set_sel] <= 1'b1;
            dirty_q[set_sel] <= 1'b0;
        end else if (write) begin
            dirty_q[set_sel] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            data_mem[set_sel][word_idx] <= wdata;
            if (last_word) begin
                tag_mem[set_sel] <= tag_in;
            end
        end else if (write) begin
            // merge only enabled bytes
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    data_mem[set_sel][word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== l1_cache/way_select.sv ====
// hit and victim selection across ways
`timescale 1ns/1ps

module way_select #(
    parameter int ASSOC = 2
) (
    input  logic [ASSOC-1:0]              way_hit,
    input  logic [ASSOC-1:0]              way_dirty,
    input  cache_pkg::tag_t [ASSOC-1:0]   way_tag,
    input  cache_pkg::word_t [ASSOC-1:0]  way_word,
    input  logic                          victim_way,
    output logic                          hit,
    output logic                          hit_way,
    output cache_pkg::word_t              hit_word,
    output logic                          victim_dirty,
    output cache_pkg::tag_t               victim_tag,
    output cache_pkg::word_t              victim_word
);
    import cache_pkg::*;

    // any way hitting, and which one
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int i = 0; i < ASSOC; i++) begin
            if (way_hit[i]) begin
                hit     = 1'b1;
                hit_way = 1'(i);
            end
        end
    end

    // requested word from the hitting way
    assign hit_word = way_word[hit_way];

    // victim line for write-back and flush
    assign victim_dirty = way_dirty[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_word  = way_word[victim_way];

endmodule

// ==== l1_cache/cache_ctrl.sv ====
// l1 data cache controller
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int ASSOC = 2
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             flush,
    input  logic                             proc_ren,
    input  logic                             proc_wen,
    input  cache_pkg::word_t                 proc_addr,
    input  cache_pkg::word_t                 proc_wdata,
    input  logic [3:0]                       proc_byte_en,
    input  cache_pkg::word_t                 mem_rdata,
    input  logic                             mem_busy,
    input  logic                             hit,
    input  logic                             hit_way,
    input  cache_pkg::word_t                 hit_word,
    input  logic                             victim_dirty,
    input  cache_pkg::tag_t                  victim_tag,
    input  cache_pkg::word_t                 victim_word,
    output logic                             flush_done,
    output cache_pkg::word_t                 proc_rdata,
    output logic                             proc_busy,
    output logic                             mem_ren,
    output logic                             mem_wen,
    output cache_pkg::word_t                 mem_addr,
    output cache_pkg::word_t                 mem_wdata,
    output cache_pkg::set_idx_t              way_set,
    output logic [cache_pkg::BLOCK_BITS-1:0] way_word_idx,
    output cache_pkg::tag_t                  way_tag,
    output cache_pkg::word_t                 way_wdata,
    output logic [3:0]                       way_byte_en,
    output logic [ASSOC-1:0]                 way_write,
    output logic [ASSOC-1:0]                 way_fill,
    output logic [ASSOC-1:0]                 way_inval,
    output logic                             victim_way
);
    import cache_pkg::*;

    // fsm encoding
    localparam logic [2:0] ST_INIT      = 3'd0;
    localparam logic [2:0] ST_IDLE      = 3'd1;
    localparam logic [2:0] ST_WRITEBACK = 3'd2;
    localparam logic [2:0] ST_FETCH     = 3'd3;
    localparam logic [2:0] ST_FLUSH     = 3'd4;

    localparam logic [BLOCK_BITS-1:0] LAST_WORD = BLOCK_BITS'(BLOCK_WORDS - 1);
    localparam set_idx_t              LAST_SET  = SET_BITS'(N_SETS - 1);
    localparam logic                  LAST_WAY  = 1'(ASSOC - 1);

    logic [2:0] state, next_state;

    // sweep position for init and flush
    set_idx_t              sweep_set, next_sweep_set;
    logic                  sweep_way, next_sweep_way;
    logic [BLOCK_BITS-1:0] sweep_word, next_sweep_word;

    // word position for write-back and fetch
    logic [BLOCK_BITS-1:0] xfer_word, next_xfer_word;

    // flush seen while busy
    logic flush_req, next_flush_req;

    // most recently used way, one bit per set
    logic [N_SETS-1:0] mru, next_mru;

    cache_addr_u req_a;
    cache_addr_u mem_a;
    logic        lru_way;
    logic        req_any;
    logic        line_done;

    assign req_a.word = proc_addr;
    assign req_any    = proc_ren | proc_wen;

    // victim is the other way, direct mapped always uses way 0
    assign lru_way = (ASSOC == 1) ? 1'b0 : ~mru[req_a.fields.set];

    // read data straight from the hitting way
    assign proc_rdata = hit_word;
    assign mem_addr   = mem_a.word;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= ST_INIT;
            sweep_set  <= '0;
            sweep_way  <= 1'b0;
            sweep_word <= '0;
            xfer_word  <= '0;
            flush_req  <= 1'b0;
            mru        <= '0;
        end else begin
            state      <= next_state;
            sweep_set  <= next_sweep_set;
            sweep_way  <= next_sweep_way;
            sweep_word <= next_sweep_word;
            xfer_word  <= next_xfer_word;
            flush_req  <= next_flush_req;
            mru        <= next_mru;
        end
    end

    always_comb begin
        next_state      = state;
        next_sweep_set  = sweep_set;
        next_sweep_way  = sweep_way;
        next_sweep_word = sweep_word;
        next_xfer_word  = xfer_word;
        next_mru        = mru;
        // keep any flush pulse until idle picks it up
        next_flush_req  = flush_req | flush;
        flush_done      = 1'b0;
        proc_busy       = 1'b1;
        mem_ren         = 1'b0;
        mem_wen         = 1'b0;
        mem_a.word      = '0;
        mem_wdata       = victim_word;
        // ways look at the request by default
        way_set         = req_a.fields.set;
        way_word_idx    = req_a.fields.block;
        way_tag         = req_a.fields.tag;
        way_wdata       = proc_wdata;
        way_byte_en     = proc_byte_en;
        way_write       = '0;
        way_fill        = '0;
        way_inval       = '0;
        victim_way      = lru_way;
        line_done       = 1'b0;

        case (state)
            ST_INIT: begin
                // clear all ways of one set per cycle
                way_set        = sweep_set;
                way_inval      = '1;
                next_sweep_set = sweep_set + 1'b1;
                if (sweep_set == LAST_SET) begin
                    next_state = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (flush || flush_req) begin
                    // flush goes ahead of any request
                    next_flush_req  = 1'b0;
                    next_sweep_set  = '0;
                    next_sweep_way  = 1'b0;
                    next_sweep_word = '0;
                    next_state      = ST_FLUSH;
                end else if (req_any) begin
                    next_xfer_word = '0;
                    if (hit) begin
                        proc_busy                      = 1'b0;
                        next_mru[req_a.fields.set]     = hit_way;
                        // read wins when both strobes are up
                        if (!proc_ren) begin
                            way_write[hit_way] = 1'b1;
                        end
                    end else if (victim_dirty) begin
                        next_state = ST_WRITEBACK;
                    end else begin
                        next_state = ST_FETCH;
                    end
                end
            end
            ST_WRITEBACK: begin
                // old line address from victim tag
                way_word_idx          = xfer_word;
                mem_wen               = 1'b1;
                mem_a.fields.tag      = victim_tag;
                mem_a.fields.set      = req_a.fields.set;
                mem_a.fields.block    = xfer_word;
                if (!mem_busy) begin
                    next_xfer_word = xfer_word + 1'b1;
                    if (xfer_word == LAST_WORD) begin
                        next_state = ST_FETCH;
                    end
                end
            end
            ST_FETCH: begin
                way_word_idx          = xfer_word;
                way_wdata             = mem_rdata;
                mem_ren               = 1'b1;
                mem_a.fields.tag      = req_a.fields.tag;
                mem_a.fields.set      = req_a.fields.set;
                mem_a.fields.block    = xfer_word;
                if (!mem_busy) begin
                    way_fill[lru_way] = 1'b1;
                    next_xfer_word    = xfer_word + 1'b1;
                    // retry as a hit once the line is valid
                    if (xfer_word == LAST_WORD) begin
                        next_state = ST_IDLE;
                    end
                end
            end
            ST_FLUSH: begin
                way_set      = sweep_set;
                way_word_idx = sweep_word;
                victim_way   = sweep_way;
                if (victim_dirty) begin
                    mem_wen            = 1'b1;
                    mem_a.fields.tag   = victim_tag;
                    mem_a.fields.set   = sweep_set;
                    mem_a.fields.block = sweep_word;
                    if (!mem_busy) begin
                        next_sweep_word = sweep_word + 1'b1;
                        line_done       = (sweep_word == LAST_WORD);
                    end
                end else begin
                    // clean or invalid line, skip in one cycle
                    line_done = 1'b1;
                end
                if (line_done) begin
                    way_inval[sweep_way] = 1'b1;
                    next_sweep_word      = '0;
                    if (sweep_way == LAST_WAY) begin
                        next_sweep_way = 1'b0;
                        next_sweep_set = sweep_set + 1'b1;
                        if (sweep_set == LAST_SET) begin
                            flush_done = 1'b1;
                            next_state = ST_IDLE;
                        end
                    end else begin
                        next_sweep_way = sweep_way + 1'b1;
                    end
                end
            end
            default: begin
                next_state = ST_INIT;
            end
        endcase
    end

endmodule

// ==== design/l1_cache_top.sv ====
// l1 data cache top level
`timescale 1ns/1ps

module l1_cache_top #(
    parameter int ASSOC = 2
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             flush,
    output logic             flush_done,
    input  logic             proc_ren,
    input  logic             proc_wen,
    input  cache_pkg::word_t proc_addr,
    input  cache_pkg::word_t proc_wdata,
    input  logic [3:0]       proc_byte_en,
    output cache_pkg::word_t proc_rdata,
    output logic             proc_busy,
    output logic             mem_ren,
    output logic             mem_wen,
    output cache_pkg::word_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    input  cache_pkg::word_t mem_rdata,
    input  logic             mem_busy
);
    import cache_pkg::*;

    // controller to ways, shared by every way
    set_idx_t              way_set;
    logic [BLOCK_BITS-1:0] way_word_idx;
    tag_t                  way_tag_in;
    word_t                 way_wdata;
    logic [3:0]            way_byte_en;

    // per-way enables
    logic [ASSOC-1:0] way_write;
    logic [ASSOC-1:0] way_fill;
    logic [ASSOC-1:0] way_inval;

    // ways to selector
    logic [ASSOC-1:0]  way_hit;
    logic [ASSOC-1:0]  way_dirty;
    tag_t [ASSOC-1:0]  way_tag_out;
    word_t [ASSOC-1:0] way_word_out;

    // selector back to controller
    logic  hit;
    logic  hit_way;
    word_t hit_word;
    logic  victim_way;
    logic  victim_dirty;
    tag_t  victim_tag;
    word_t victim_word;

    cache_ctrl #(
        .ASSOC(ASSOC)
    ) u_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .proc_ren    (proc_ren),
        .proc_wen    (proc_wen),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .proc_byte_en(proc_byte_en),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_word    (hit_word),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .victim_word (victim_word),
        .flush_done  (flush_done),
        .proc_rdata  (proc_rdata),
        .proc_busy   (proc_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .way_set     (way_set),
        .way_word_idx(way_word_idx),
        .way_tag     (way_tag_in),
        .way_wdata   (way_wdata),
        .way_byte_en (way_byte_en),
        .way_write   (way_write),
        .way_fill    (way_fill),
        .way_inval   (way_inval),
        .victim_way  (victim_way)
    );

    // one storage block per way
    generate
        for (genvar w = 0; w < ASSOC; w++) begin : g_way
            cache_way u_way (
                .CLK     (CLK),
                .nRST    (nRST),
                .set_sel (way_set),
                .word_idx(way_word_idx),
                .tag_in  (way_tag_in),
                .wdata   (way_wdata),
                .byte_en (way_byte_en),
                .write   (way_write[w]),
                .fill    (way_fill[w]),
                .inval   (way_inval[w]),
                .hit     (way_hit[w]),
                .dirty   (way_dirty[w]),
                .tag_out (way_tag_out[w]),
                .word_out(way_word_out[w])
            );
        end
    endgenerate

    way_select #(
        .ASSOC(ASSOC)
    ) u_select (
        .way_hit     (way_hit),
        .way_dirty   (way_dirty),
        .way_tag     (way_tag_out),
        .way_word    (way_word_out),
        .victim_way  (victim_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_word    (hit_word),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag),
        .victim_word (victim_word)
    );

endmodule

// ==== verif/tb_clock.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);
    // free running clock, low first
    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD / 2);
            CLK = ~CLK;
        end
    end

    // reset held for a fixed number of rising edges
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        // release off the edge
        #1;
        nRST = 1'b1;
    end

endmodule

// ==== verif/l1_cache_asserts.sv ====
// memory port and flush protocol assertions
`timescale 1ns/1ps

module l1_cache_asserts (
    input logic             CLK,
    input logic             nRST,
    input logic             flush_done,
    input logic             mem_ren,
    input logic             mem_wen,
    input cache_pkg::word_t mem_addr,
    input cache_pkg::word_t mem_wdata,
    input logic             mem_busy
);
    // failures so far, read by the testbench top
    int unsigned fail_count = 0;

    // never read and write at once
    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
    else begin
        $error("mem_ren and mem_wen high together");
        fail_count++;
    end

    // done is a single cycle pulse
    a_flush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
    else begin
        $error("flush_done high for more than one cycle");
        fail_count++;
    end

    // stalled request keeps strobe and address
    a_addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=>
            (mem_ren == $past(mem_ren)) && (mem_wen == $past(mem_wen)) && $stable(mem_addr))
    else begin
        $error("memory request changed while mem_busy was high");
        fail_count++;
    end

    // stalled write keeps its data
    a_wdata_hold: assert property (@(posedge CLK) disable iff (!nRST)
        mem_wen && mem_busy |=> mem_wen && $stable(mem_wdata))
    else begin
        $error("mem_wdata changed while mem_busy was high");
        fail_count++;
    end

endmodule

bind l1_cache_top l1_cache_asserts u_asserts (
    .CLK       (CLK),
    .nRST      (nRST),
    .flush_done(flush_done),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_busy  (mem_busy)
);

// ==== verif/tb_l1_cache.sv ====
// l1 data cache testbench
`timescale 1ns/1ps

module tb_l1_cache;
    import cache_pkg::*;

    localparam int          TIMEOUT     = 200;
    localparam int          TRACE_WORDS = 256;
    localparam int          MEM_WORDS   = 1024;
    localparam logic [31:0] SEED        = 32'h743d_720e;

    // op codes of the four word trace entries
    localparam word_t OP_READ  = 32'd1;
    localparam word_t OP_WRITE = 32'd2;
    localparam word_t OP_FLUSH = 32'd3;
    localparam word_t OP_CHECK = 32'd4;

    logic       CLK;
    logic       nRST;
    logic       flush;
    logic       flush_done;
    logic       proc_ren;
    logic       proc_wen;
    word_t      proc_addr;
    word_t      proc_wdata;
    logic [3:0] proc_byte_en;
    word_t      proc_rdata;
    logic       proc_busy;
    logic       mem_ren;
    logic       mem_wen;
    word_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;
    logic       mem_busy;

    // backing memory with one entry per word
    word_t mem_model [MEM_WORDS];
    // raw trace words
    word_t trace_mem [TRACE_WORDS];

    tb_clock #(
        .PERIOD      (100),
        .RESET_CYCLES(8)
    ) u_clock (
        .CLK (CLK),
        .nRST(nRST)
    );

    l1_cache_top #(
        .ASSOC(2)
    ) dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .flush_done  (flush_done),
        .proc_ren    (proc_ren),
        .proc_wen    (proc_wen),
        .proc_addr   (proc_addr),
        .proc_wdata  (proc_wdata),
        .proc_byte_en(proc_byte_en),
        .proc_rdata  (proc_rdata),
        .proc_busy   (proc_busy),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy)
    );

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
            abort_run();
        end
    endtask

    // one processor request held until proc_busy drops
    task automatic proc_access(input logic is_write, input word_t addr, input word_t wdata,
                               input logic [3:0] byte_en, output word_t rdata);
        int cycles;
        cycles       = 0;
        proc_ren     = ~is_write;
        proc_wen     = is_write;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = byte_en;
        // sample mid cycle
        @(negedge CLK);
        while (proc_busy && cycles < TIMEOUT) begin
            cycles++;
            @(negedge CLK);
        end
        assert (!proc_busy) else begin
            $display("timeout, proc_busy stayed high after a request to %h", addr);
            abort_run();
        end
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    // single flush pulse and wait for flush_done
    task automatic flush_cache();
        int cycles;
        cycles = 0;
        flush  = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        @(negedge CLK);
        while (!flush_done && cycles < TIMEOUT) begin
            cycles++;
            @(negedge CLK);
        end
        assert (flush_done) else begin
            $display("timeout, flush_done never came after a flush request");
            abort_run();
        end
        @(posedge CLK);
        #1;
    endtask

    // memory model with 0 to 2 busy cycles per word
    initial begin
        int   wait_left;
        logic xfer_active;
        wait_left   = 0;
        xfer_active = 1'b0;
        mem_busy    = 1'b0;
        mem_rdata   = '0;
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++) begin
            // pattern from the full byte address
            mem_model[i] = word_t'(i * 4) ^ 32'h5a5a_5a5a;
        end
        forever begin
            // transfer finishes at the coming edge
            @(negedge CLK);
            if ((mem_ren || mem_wen) && !mem_busy) begin
                if (mem_wen) begin
                    mem_model[mem_addr[11:2]] = mem_wdata;
                end
                xfer_active = 1'b0;
            end
            @(posedge CLK);
            #1;
            if (mem_ren || mem_wen) begin
                assert (mem_addr < MEM_WORDS * 4) else begin
                    $display("memory access at %h is outside the memory model", mem_addr);
                    abort_run();
                end
                // pick the wait of a new word
                if (!xfer_active) begin
                    xfer_active = 1'b1;
                    wait_left   = $urandom % 3;
                end
                mem_busy = (wait_left != 0);
                if (wait_left != 0) begin
                    wait_left--;
                end
                mem_rdata = mem_model[mem_addr[11:2]];
            end else begin
                mem_busy = 1'b0;
            end
        end
    end

    // bound protocol checks
    always @(negedge CLK) begin
        assert (dut.u_asserts.fail_count == 0) else begin
            $display("a protocol assertion on the memory port or flush_done failed");
            abort_run();
        end
    end

    initial begin
        int    cycles;
        int    idx;
        int    ops_done;
        logic  finished;
        word_t op;
        word_t addr;
        word_t data;
        word_t got;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("verif/l1_cache_trace.txt", trace_mem);

        cycles = 0;
        while (nRST !== 1'b1 && cycles < TIMEOUT) begin
            cycles++;
            @(posedge CLK);
        end
        assert (nRST === 1'b1) else begin
            $display("reset was never released");
            abort_run();
        end
        @(posedge CLK);
        #1;

        idx      = 0;
        ops_done = 0;
        finished = 1'b0;
        while (!finished) begin
            op   = trace_mem[4 * idx];
            addr = trace_mem[4 * idx + 1];
            data = trace_mem[4 * idx + 2];
            assert (op <= OP_CHECK) else begin
                $display("unknown op %h on trace entry %0d", op, idx);
                abort_run();
            end
            case (op)
                OP_READ: begin
                    proc_access(1'b0, addr, '0, 4'hf, got);
                    check_word($sformatf("proc_rdata at %h", addr), got, data);
                end
                OP_WRITE: begin
                    proc_access(1'b1, addr, data, trace_mem[4 * idx + 3][3:0], got);
                end
                OP_FLUSH: begin
                    flush_cache();
                end
                OP_CHECK: begin
                    check_word($sformatf("mem_model[%h]", addr), mem_model[addr[11:2]], data);
                end
                default: begin
                    // end marker
                    finished = 1'b1;
                end
            endcase
            if (!finished) begin
                ops_done++;
            end
            idx++;
            if (idx == TRACE_WORDS / 4) begin
                finished = 1'b1;
            end
        end

        if (ops_done > 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("no operations were read from the trace file");
            abort_run();
        end
    end

endmodule

// ==== verif/l1_cache_trace.txt ====
// columns in hex: op addr data byte_en
// op 1 read (data is expected), 2 write, 3 flush, 4 memory check (data is expected), 0 end
1 00000100 5a5a5b5a 0  // first read misses, initial pattern
1 00000104 5a5a5b5e 0  // other word of the block hits
2 00000100 deadbeef 5  // bytes 0 and 2 only
1 00000100 5aad5bef 0
2 00000104 12345678 f  // block at 100 now dirty in both words
1 00000140 5a5a5b1a 0  // second block in set 0
1 00000104 12345678 0
1 00000144 5a5a5b1e 0  // block at 100 is now lru
4 00000100 5a5a5b5a 0  // not yet written back
1 00000180 5a5a5bda 0  // third block evicts dirty lru
4 00000100 5aad5bef 0
4 00000104 12345678 0
1 00000140 5a5a5b1a 0  // still resident
1 00000100 5aad5bef 0  // refetched from memory
2 00000208 aabbccdd f  // write allocate in set 1
2 0000004c 0f0f0f0f 3
2 00000140 cafef00d 8
4 00000208 5a5a5852 0
3 00000000 00000000 0  // flush
4 00000208 aabbccdd 0
4 0000004c 5a5a0f0f 0
4 00000048 5a5a5a12 0
4 00000140 ca5a5b1a 0
4 00000100 5aad5bef 0
1 00000208 aabbccdd 0  // misses after flush
1 00000144 5a5a5b1e 0
1 0000004c 5a5a0f0f 0
0 00000000 00000000 0

// ==== tb.f ====
common/cache_pkg.sv
l1_cache/cache_way.sv
l1_cache/way_select.sv
l1_cache/cache_ctrl.sv
design/l1_cache_top.sv
verif/tb_clock.sv
verif/l1_cache_asserts.sv
verif/tb_l1_cache.sv
